// ==== routerPkg.sv ====
package routerPkg;

  localparam int numPorts = 5;

  // flit kinds, one-hot.
  typedef logic [2:0] flitKind_t;

  localparam flitKind_t kindHeader = 3'b001;
  localparam flitKind_t kindBody   = 3'b010;
  localparam flitKind_t kindTail   = 3'b100;

  typedef logic [11:0] payload_t;

  // header payload doubles as the grant budget in cycles.
  typedef logic [11:0] budget_t;

  typedef struct packed {
    flitKind_t kind;
    payload_t  payload;
  } flit_t;

  typedef enum logic [2:0] {
    portL,
    portN,
    portE,
    portW,
    portS
  } portId_t;

  typedef struct packed {
    portId_t srcPort;
    flit_t   flit;
  } outFlit_t;

  // grant states sit at bit (port + 1).
  typedef enum logic [5:0] {
    stIdle   = 6'b000001,
    stGrantL = 6'b000010,
    stGrantN = 6'b000100,
    stGrantE = 6'b001000,
    stGrantW = 6'b010000,
    stGrantS = 6'b100000
  } arbState_t;

endpackage

// ==== flitFifo.sv ====
`timescale 1ns/10ps

module flitFifo
  import routerPkg::*;
#(
  parameter int fifoDepth = 8
)
(
  input  logic  clk,
  input  logic  rst,
  input  logic  wrEn,
  input  flit_t wrData,
  input  logic  rdEn,
  output flit_t rdData,
  output logic  empty,
  output logic  full
);

  localparam int ptrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
  localparam int cntW = $clog2(fifoDepth + 1);

  flit_t           mem [fifoDepth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;

  always_ff @(posedge clk)
  begin
    if (wrEn)
      mem[wrPtr] <= wrData;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (wrEn)
        wrPtr <= (wrPtr == ptrW'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (rdEn)
        rdPtr <= (rdPtr == ptrW'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
      case ({wrEn, rdEn})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign rdData = mem[rdPtr]; // head flit, stale when empty.
  assign empty  = (count == '0);
  assign full   = (count == cntW'(fifoDepth));

  assert property (@(posedge clk) disable iff (rst) !(wrEn && full));
  assert property (@(posedge clk) disable iff (rst) !(rdEn && empty));

endmodule

// ==== inputPort.sv ====
`timescale 1ns/10ps

module inputPort
  import routerPkg::*;
#(
  parameter int fifoDepth = 8
)
(
  input  logic  clk,
  input  logic  rst,
  input  logic  push,
  input  flit_t inFlit,
  input  logic  pop,
  output flit_t headFlit,
  output logic  req,
  output logic  full
);

  logic empty;

  // one buffer per input port.
  flitFifo #(
    .fifoDepth(fifoDepth)
  ) fifo0 (
    .clk    (clk),
    .rst    (rst),
    .wrEn   (push),
    .wrData (inFlit),
    .rdEn   (pop),
    .rdData (headFlit),
    .empty  (empty),
    .full   (full)
  );

  // request as long as anything is queued.
  assign req = !empty;

  // the grant comes back from the arbiter a cycle later in time.
  assert property (@(posedge clk) disable iff (rst) pop |-> req);

endmodule

// ==== portTimer.sv ====
`timescale 1ns/10ps

module portTimer
  import routerPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  flit_t headFlit,
  input  logic  runTimer,
  output logic  timesUp
);

  budget_t budget;
  budget_t count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count  <= '0;
    end
    else
    begin
      if (headFlit.kind == kindHeader)
        budget <= headFlit.payload; // reload on every header seen.
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == budget);

endmodule

// ==== switchArbiter.sv ====
`timescale 1ns/10ps

module switchArbiter
  import routerPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [numPorts-1:0] req,
  input  flit_t               headFlit [numPorts],
  output logic [numPorts-1:0] grant
);

  arbState_t           state;
  arbState_t           nextState;
  logic [numPorts-1:0] runTimer;
  logic [numPorts-1:0] timesUp;

  function automatic arbState_t grantStateOf(int unsigned idx);
    case (idx)
      0:       return stGrantL;
      1:       return stGrantN;
      2:       return stGrantE;
      3:       return stGrantW;
      4:       return stGrantS;
      default: return stIdle;
    endcase
  endfunction

  // first requester at or after port first, wrapping round.
  function automatic arbState_t pickNext(logic [numPorts-1:0] r, int unsigned first);
    arbState_t   pick;
    int unsigned idx;
    pick = stIdle;
    // scan backwards so the nearest requester wins.
    for (int i = numPorts - 1; i >= 0; i--)
    begin
      idx = (first + i) % numPorts;
      if (r[idx])
        pick = grantStateOf(idx);
    end
    return pick;
  endfunction

  for (genvar i = 0; i < numPorts; i++)
  begin : gTimer
    portTimer timer0 (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlit[i]),
      .runTimer (runTimer[i]),
      .timesUp  (timesUp[i])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stIdle;
    else
      state <= nextState;
  end

  // relies on the one-hot state layout.
  assign grant    = state[numPorts:1] & req;
  assign runTimer = grant & ~timesUp; // holder keeps the link.

  always_comb
  begin
    nextState = stIdle;
    case (state)
      stIdle:
        nextState = pickNext(req, portL);
      stGrantL:
      begin
        if (runTimer[portL])
          nextState = stGrantL;
        else
          nextState = pickNext(req, portN);
      end
      stGrantN:
      begin
        if (runTimer[portN])
          nextState = stGrantN;
        else
          nextState = pickNext(req, portE);
      end
      stGrantE:
      begin
        if (runTimer[portE])
          nextState = stGrantE;
        else
          nextState = pickNext(req, portW);
      end
      stGrantW:
      begin
        if (runTimer[portW])
          nextState = stGrantW;
        else
          nextState = pickNext(req, portS);
      end
      stGrantS:
      begin
        if (runTimer[portS])
          nextState = stGrantS;
        else
          nextState = pickNext(req, portL);
      end
      default:
        nextState = stIdle;
    endcase
  end

  assert property (@(posedge clk) disable iff (rst) $onehot0(grant));
  assert property (@(posedge clk) disable iff (rst) $onehot(state));

endmodule

// ==== outputStage.sv ====
`timescale 1ns/10ps

module outputStage
  import routerPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [numPorts-1:0] grant,
  input  flit_t               headFlit [numPorts],
  output logic                outValid,
  output outFlit_t            outFlit
);

  portId_t srcSel;
  flit_t   flitSel;

  // one-hot grant to port id.
  always_comb
  begin
    srcSel = portL;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
        srcSel = portId_t'(i);
    end
  end

  assign flitSel = headFlit[srcSel];

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |grant;
  end

  // payload only meaningful with outValid.
  always_ff @(posedge clk)
  begin
    outFlit.srcPort <= srcSel;
    outFlit.flit    <= flitSel;
  end

endmodule

// ==== routerOutputTop.sv ====
`timescale 1ns/10ps

module routerOutputTop
  import routerPkg::*;
#(
  parameter int fifoDepth = 8
)
(
  input  logic                clk,
  input  logic                rst,
  input  logic [numPorts-1:0] push,
  input  flit_t               inFlit [numPorts],
  output logic [numPorts-1:0] full,
  output logic                outValid,
  output outFlit_t            outFlit
);

  logic [numPorts-1:0] req;
  logic [numPorts-1:0] grant;
  flit_t               headFlit [numPorts];

  for (genvar i = 0; i < numPorts; i++)
  begin : gPort
    inputPort #(
      .fifoDepth(fifoDepth)
    ) inPort (
      .clk      (clk),
      .rst      (rst),
      .push     (push[i]),
      .inFlit   (inFlit[i]),
      .pop      (grant[i]), // grant pops the same cycle.
      .headFlit (headFlit[i]),
      .req      (req[i]),
      .full     (full[i])
    );
  end

  switchArbiter arb0 (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .headFlit (headFlit),
    .grant    (grant)
  );

  outputStage out0 (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .headFlit (headFlit),
    .outValid (outValid),
    .outFlit  (outFlit)
  );

endmodule

// ==== tbVectors.svh ====
localparam logic [7:0] noTag = 8'hff; // any output slot.

localparam int idleCycles  = 10;
localparam int fairStart   = 50;
localparam int fairBudget  = 2;
localparam int tableCycles = 100;
localparam int numVecs     = 25;

typedef struct packed {
  logic [15:0] cycle;
  portId_t     port;
  flitKind_t   kind;
  payload_t    payload;
  logic [7:0]  tag;
} vecEntry_t;

// columns: start cycle, port, kind, payload, expected output slot.
// body payloads carry the port in bits 11:8 and a sequence number below.
localparam vecEntry_t vecs [numVecs] = '{
  '{16'd10, portE, kindHeader, 12'd3,   8'd0}, // one packet on E, budget 3.
  '{16'd11, portE, kindBody,   12'h201, 8'd1},
  '{16'd12, portE, kindBody,   12'h202, 8'd2},
  '{16'd13, portE, kindTail,   12'h203, 8'd3},
  '{16'd30, portL, kindHeader, 12'd0,   8'd4}, // all five at once from idle.
  '{16'd30, portN, kindHeader, 12'd0,   8'd5},
  '{16'd30, portE, kindHeader, 12'd0,   8'd6},
  '{16'd30, portW, kindHeader, 12'd0,   8'd7},
  '{16'd30, portS, kindHeader, 12'd0,   8'd8},
  '{16'd50, portN, kindHeader, 12'd2,   noTag}, // N and W compete.
  '{16'd50, portW, kindHeader, 12'd2,   noTag},
  '{16'd51, portN, kindBody,   12'h101, noTag},
  '{16'd51, portW, kindBody,   12'h301, noTag},
  '{16'd52, portN, kindBody,   12'h102, noTag},
  '{16'd52, portW, kindBody,   12'h302, noTag},
  '{16'd53, portN, kindBody,   12'h103, noTag},
  '{16'd53, portW, kindBody,   12'h303, noTag},
  '{16'd54, portN, kindBody,   12'h104, noTag},
  '{16'd54, portW, kindBody,   12'h304, noTag},
  '{16'd55, portN, kindBody,   12'h105, noTag},
  '{16'd55, portW, kindBody,   12'h305, noTag},
  '{16'd56, portN, kindBody,   12'h106, noTag},
  '{16'd56, portW, kindBody,   12'h306, noTag},
  '{16'd57, portN, kindTail,   12'h107, noTag},
  '{16'd57, portW, kindTail,   12'h307, noTag}
};

// ==== tbRouterOutput.sv ====
`timescale 1ns/10ps

module tbRouterOutput
  import routerPkg::*;
();

  `include "tbVectors.svh"

  localparam int randFlits      = 200;
  localparam int watchdogCycles = tableCycles + randFlits * 10 + 200;

  typedef struct packed {
    logic [7:0] tag;
    flit_t      flit;
  } expFlit_t;

  logic                clk;
  logic                rst;
  logic [numPorts-1:0] push;
  flit_t               inFlit [numPorts];
  logic [numPorts-1:0] full;
  logic                outValid;
  outFlit_t            outFlit;

  expFlit_t   expQ [numPorts][$]; // pending flits per source port.
  logic [7:0] pushTag [numPorts];
  int         pktLeft [numPorts];
  int         seqNo [numPorts];
  int         errors;
  int         checks;
  int         outCount;
  int         runLen;
  int         sent;
  int         openPkts;
  portId_t    runPort;
  logic       idleOn;
  logic       fairOn;
  string      testName;
  integer     seed;

  routerOutputTop #(
    .fifoDepth(8)
  ) dut0 (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .inFlit   (inFlit),
    .full     (full),
    .outValid (outValid),
    .outFlit  (outFlit)
  );

  always #2 clk = ~clk;

  function automatic string phaseName(int c);
    if (c < idleCycles)
      return "reset idle";
    else if (c < 30)
      return "single packet E";
    else if (c < fairStart)
      return "five-port order";
    return "budget fairness";
  endfunction

  function automatic logic otherPending(int p);
    logic busy;
    busy = 1'b0;
    for (int i = 0; i < numPorts; i++)
      if (i != p && expQ[i].size() > 0)
        busy = 1'b1;
    return busy;
  endfunction

  function automatic int pendingCount();
    int n;
    n = 0;
    for (int i = 0; i < numPorts; i++)
      n += expQ[i].size();
    return n;
  endfunction

  task automatic applyEntry(vecEntry_t e);
    checks++;
    assert (!full[e.port])
    else
    begin
      errors++;
      $display("%s: table pushes into full port %0d", testName, e.port);
    end
    push[e.port]    = 1'b1;
    inFlit[e.port]  = '{kind: e.kind, payload: e.payload};
    pushTag[e.port] = e.tag;
  endtask

  task automatic randomFlit(int p);
    flit_t f;
    if (pktLeft[p] == 0)
    begin
      f.kind     = kindHeader;
      f.payload  = payload_t'($unsigned($random(seed)) % 8); // budget.
      pktLeft[p] = 1 + $unsigned($random(seed)) % 6;
      openPkts++;
    end
    else
    begin
      pktLeft[p]--;
      seqNo[p]++;
      f.kind    = (pktLeft[p] == 0) ? kindTail : kindBody;
      f.payload = payload_t'((p << 8) | (seqNo[p] & 8'hff));
      if (pktLeft[p] == 0)
        openPkts--;
    end
    push[p]    = 1'b1;
    inFlit[p]  = f;
    pushTag[p] = noTag;
    sent++;
  endtask

  // the DUT takes pushes on this same edge.
  task automatic recordPushes();
    for (int p = 0; p < numPorts; p++)
      if (push[p])
        expQ[p].push_back('{tag: pushTag[p], flit: inFlit[p]});
  endtask

  always @(negedge clk)
  begin
    expFlit_t head;
    int       src;
    if (idleOn)
    begin
      checks++;
      assert (!outValid && full == '0)
      else
      begin
        errors++;
        $display("[FAIL] %s: expected outValid 0 full 00000, actual outValid %b full %b",
                 testName, outValid, full);
      end
    end
    if (!outValid)
      runLen = 0;
    else
    begin
      src = int'(outFlit.srcPort);
      checks++;
      assert (src < numPorts && expQ[src].size() > 0)
      else
      begin
        errors++;
        $display("%s: output flit from port %0d with nothing pending there", testName, src);
      end
      if (src < numPorts && expQ[src].size() > 0)
      begin
        head = expQ[src].pop_front();
        checks++;
        assert (outFlit.flit == head.flit)
        else
        begin
          errors++;
          $display("[FAIL] %s port %0d flit: expected %h, actual %h",
                   testName, src, head.flit, outFlit.flit);
        end
        if (head.tag != noTag)
        begin
          checks++;
          assert (outCount == int'(head.tag))
          else
          begin
            errors++;
            $display("[FAIL] %s order: expected slot %0d, actual slot %0d",
                     testName, head.tag, outCount);
          end
        end
      end
      runLen  = (outFlit.srcPort == runPort) ? runLen + 1 : 1;
      runPort = outFlit.srcPort;
      if (fairOn && runLen > fairBudget + 1)
      begin
        checks++;
        assert (!otherPending(src))
        else
        begin
          errors++;
          $display("[FAIL] %s run length: expected at most %0d, actual %0d",
                   testName, fairBudget + 1, runLen);
        end
      end
      outCount++;
    end
  end

  initial
  begin
    clk      = 1'b0;
    rst      = 1'b1;
    push     = '0;
    errors   = 0;
    checks   = 0;
    outCount = 0;
    runLen   = 0;
    sent     = 0;
    openPkts = 0;
    runPort  = portL;
    idleOn   = 1'b0;
    fairOn   = 1'b0;
    testName = phaseName(0);
    seed     = 32'h86984f66;
    for (int p = 0; p < numPorts; p++)
    begin
      inFlit[p]  = '0;
      pushTag[p] = noTag;
      pktLeft[p] = 0;
      seqNo[p]   = 0;
    end
    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    idleOn = 1'b1;
    for (int c = 0; c < tableCycles; c++)
    begin
      @(negedge clk);
      push = '0;
      for (int v = 0; v < numVecs; v++)
        if (int'(vecs[v].cycle) == c)
          applyEntry(vecs[v]);
      @(posedge clk);
      recordPushes();
      idleOn   = (c + 1 < idleCycles);
      fairOn   = (c + 1 >= fairStart);
      testName = phaseName(c + 1);
    end
    fairOn   = 1'b0;
    testName = "random stream";
    while (sent < randFlits || openPkts > 0)
    begin
      @(negedge clk);
      push = '0;
      for (int p = 0; p < numPorts; p++)
        if (!full[p] && ($random(seed) & 1) == 0 && (pktLeft[p] > 0 || sent < randFlits))
          randomFlit(p);
      @(posedge clk);
      recordPushes();
    end
    @(negedge clk);
    push = '0;
    for (int w = 0; w < 300 && pendingCount() > 0; w++)
      @(posedge clk);
    repeat (10) @(posedge clk); // catch stray outputs.
    for (int p = 0; p < numPorts; p++)
    begin
      checks++;
      assert (expQ[p].size() == 0)
      else
      begin
        errors++;
        $display("[FAIL] %s port %0d leftover: expected 0, actual %0d",
                 testName, p, expQ[p].size());
      end
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  initial
  begin
    #(watchdogCycles * 4);
    $display("timeout: router still busy after %0d cycles", watchdogCycles);
    $display("checks %0d, errors %0d", checks, errors);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
routerPkg.sv
flitFifo.sv
inputPort.sv
portTimer.sv
switchArbiter.sv
outputStage.sv
routerOutputTop.sv
tbRouterOutput.sv
